// File: source/flowMux_settings.svh
// Flow mux build settings
// Flow count and data width shared by the round-robin mux and its testbench

`ifndef FLOW_MUX_SETTINGS_SVH
`define FLOW_MUX_SETTINGS_SVH

// Number of push flows merged onto the pop side
`define FLOW_MUX_NUM_FLOWS 4

// Width of one data word in bits
`define FLOW_MUX_DATA_WIDTH 8

// Flow index width, never below one bit
`define FLOW_MUX_INDEX_WIDTH \
  (($clog2(`FLOW_MUX_NUM_FLOWS) > 0) ? $clog2(`FLOW_MUX_NUM_FLOWS) : 1)

`endif

// File: source/flowMuxPkg.sv
// Flow mux types
// Vector typedefs for per-flow masks, flow indices and data words

`include "flowMux_settings.svh"

package flowMuxPkg;

  // -------------------------------------------------------------------------
  // Widths with a meaning
  // -------------------------------------------------------------------------

  // One bit per flow, used for valids, readies, requests and grants
  typedef logic [`FLOW_MUX_NUM_FLOWS-1:0] flowMask_t;

  // Payload word carried by each flow
  typedef logic [`FLOW_MUX_DATA_WIDTH-1:0] flowData_t;

  // Flow number, used by the arbiter pointer
  typedef logic [`FLOW_MUX_INDEX_WIDTH-1:0] flowIndex_t;

endpackage : flowMuxPkg

// File: source/rrArbiter.sv
// Round-robin arbiter
// Grants the first requester after the last granted flow in cyclic order.
// The request to grant path is combinational; the pointer only moves
// when the downstream side reports a completed transfer.

`include "flowMux_settings.svh"

module rrArbiter (
  input  logic                  clk,
  input  logic                  arstN,
  input  flowMuxPkg::flowMask_t request,
  input  logic                  enablePriorityUpdate,
  output flowMuxPkg::flowMask_t grant
);

  import flowMuxPkg::*;

  // -------------------------------------------------------------------------
  // Priority state
  // -------------------------------------------------------------------------

  // Index of the flow that won the last completed transfer
  flowIndex_t lastGrant;

  // Index of the flow granted in this cycle
  flowIndex_t winnerIndex;

  // -------------------------------------------------------------------------
  // Winner search
  // -------------------------------------------------------------------------

  // Walk the flows starting just after the pointer and wrap around
  // The pointer itself is checked last so it has the lowest priority
  always_comb begin : findWinner
    int   candidate;
    logic found;
    grant       = '0;
    winnerIndex = lastGrant;
    found       = 1'b0;
    candidate   = 0;
    for (int offset = 1; offset <= `FLOW_MUX_NUM_FLOWS; offset++) begin
      // Modulo keeps the search correct for non power of two flow counts
      candidate = (int'(lastGrant) + offset) % `FLOW_MUX_NUM_FLOWS;
      if (!found && request[candidate]) begin
        found            = 1'b1;
        grant[candidate] = 1'b1;
        winnerIndex      = flowIndex_t'(candidate);
      end
    end
  end

  // -------------------------------------------------------------------------
  // Pointer update
  // -------------------------------------------------------------------------

  // Reset to the highest flow so flow 0 wins first
  // Holds under back-pressure, moves one cycle after a transfer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lastGrant <= flowIndex_t'(`FLOW_MUX_NUM_FLOWS - 1);
    end else if (enablePriorityUpdate) begin
      // Only raised together with pop valid, so winnerIndex is a real grant
      lastGrant <= winnerIndex;
    end
  end

endmodule : rrArbiter

// File: source/flowMuxCore.sv
// Flow mux datapath
// Selects the granted push flow onto the pop side and returns pop ready
// to that flow only. Purely combinational, zero cycles from push to pop.

`include "flowMux_settings.svh"

module flowMuxCore (
  input  flowMuxPkg::flowMask_t pushValid,
  input  flowMuxPkg::flowData_t pushData [`FLOW_MUX_NUM_FLOWS],
  output flowMuxPkg::flowMask_t pushReady,
  input  logic                  popReady,
  output logic                  popValidUnstable,
  output flowMuxPkg::flowData_t popDataUnstable,
  output flowMuxPkg::flowMask_t request,
  input  flowMuxPkg::flowMask_t grant,
  output logic                  enablePriorityUpdate
);

  import flowMuxPkg::*;

  // Word picked by the one-hot grant
  flowData_t selectedData;

  // -------------------------------------------------------------------------
  // Arbiter requests
  // -------------------------------------------------------------------------

  // Every valid flow competes for the pop side
  assign request = pushValid;

  // -------------------------------------------------------------------------
  // Data select
  // -------------------------------------------------------------------------

  // AND-OR mux, relies on grant being one-hot or zero
  // Zero grant gives an all-zero word
  always_comb begin : selectData
    selectedData = '0;
    for (int flow = 0; flow < `FLOW_MUX_NUM_FLOWS; flow++) begin
      selectedData |= pushData[flow] & {`FLOW_MUX_DATA_WIDTH{grant[flow]}};
    end
  end

  // Follows the grant, may change while pop is stalled
  assign popDataUnstable = selectedData;

  // -------------------------------------------------------------------------
  // Handshake
  // -------------------------------------------------------------------------

  // Any grant means some flow is valid
  assign popValidUnstable = |grant;

  // Ready goes back to the granted flow only
  // Stalled pop side blocks every push flow
  assign pushReady = grant & {`FLOW_MUX_NUM_FLOWS{popReady}};

  // Transfer happens this cycle, pointer moves at the next edge
  assign enablePriorityUpdate = popValidUnstable & popReady;

endmodule : flowMuxCore

// File: source/flowMuxRr.sv
// Round-robin flow mux
// Merges several valid/ready push flows onto one pop flow. The arbiter
// keeps the priority state while the core steers data and ready.
// Pop data and valid are unstable under back-pressure.

`include "flowMux_settings.svh"

module flowMuxRr (
  input  logic                  clk,
  input  logic                  arstN,
  input  flowMuxPkg::flowMask_t pushValid,
  input  flowMuxPkg::flowData_t pushData [`FLOW_MUX_NUM_FLOWS],
  output flowMuxPkg::flowMask_t pushReady,
  input  logic                  popReady,
  // Drops if every push valid is withdrawn while popReady is low
  output logic                  popValidUnstable,
  // Switches if a higher priority flow arrives while popReady is low
  output flowMuxPkg::flowData_t popDataUnstable
);

  import flowMuxPkg::*;

  // -------------------------------------------------------------------------
  // Arbiter to core wiring
  // -------------------------------------------------------------------------

  flowMask_t request;
  flowMask_t grant;
  logic      enablePriorityUpdate;

  // Priority state and grant
  rrArbiter arbiter (
    .clk                  (clk),
    .arstN                (arstN),
    .request              (request),
    .enablePriorityUpdate (enablePriorityUpdate),
    .grant                (grant)
  );

  // Data select and ready routing
  flowMuxCore muxCore (
    .pushValid            (pushValid),
    .pushData             (pushData),
    .pushReady            (pushReady),
    .popReady             (popReady),
    .popValidUnstable     (popValidUnstable),
    .popDataUnstable      (popDataUnstable),
    .request              (request),
    .grant                (grant),
    .enablePriorityUpdate (enablePriorityUpdate)
  );

endmodule : flowMuxRr

// File: testbench/flowMux_props.sv
// Flow mux handshake checks
// Concurrent assertions on the top-level ports, bound into the mux

`include "flowMux_settings.svh"

module flowMuxProps (
  input logic                  clk,
  input logic                  arstN,
  input flowMuxPkg::flowMask_t pushValid,
  input flowMuxPkg::flowMask_t pushReady,
  input logic                  popReady,
  input logic                  popValidUnstable
);

  import flowMuxPkg::*;

  // Flows that may legally see ready this cycle
  flowMask_t allowedReady;

  assign allowedReady = pushValid & {`FLOW_MUX_NUM_FLOWS{popReady}};

  // -------------------------------------------------------------------------
  // Properties
  // -------------------------------------------------------------------------

  // At most one flow accepted per cycle
  readyOneHot: assert property (@(posedge clk) disable iff (!arstN)
    $onehot0(pushReady))
    else $error("pushReady has more than one bit set");

  // Ready only toward a valid flow with the pop side open
  readyAllowed: assert property (@(posedge clk) disable iff (!arstN)
    (pushReady & ~allowedReady) == '0)
    else $error("pushReady set without pushValid and popReady");

  // Zero latency, pop valid mirrors any push valid
  validFollows: assert property (@(posedge clk) disable iff (!arstN)
    popValidUnstable == (|pushValid))
    else $error("popValidUnstable differs from the OR of pushValid");

endmodule : flowMuxProps

bind flowMuxRr flowMuxProps props (
  .clk              (clk),
  .arstN            (arstN),
  .pushValid        (pushValid),
  .pushReady        (pushReady),
  .popReady         (popReady),
  .popValidUnstable (popValidUnstable)
);

// File: testbench/flowMuxTb.sv
// Flow mux testbench
// Replays a per-cycle trace of push and pop stimulus into the round-robin
// mux and checks pushReady, pop valid and pop data before every clock edge

`include "flowMux_settings.svh"

module flowMuxTb;

  import flowMuxPkg::*;

  localparam int    ClockPeriod    = 8;
  localparam int    ResetCycles    = 10;
  localparam int    WatchdogMargin = 20;
  localparam int    MaxTraceLines  = 256;
  localparam string TracePath      = "testbench/flowMux_trace.txt";

  // -------------------------------------------------------------------------
  // DUT signals
  // -------------------------------------------------------------------------

  logic      clk;
  logic      arstN;
  flowMask_t pushValid;
  flowData_t pushData [`FLOW_MUX_NUM_FLOWS];
  flowMask_t pushReady;
  logic      popReady;
  logic      popValidUnstable;
  flowData_t popDataUnstable;

  // -------------------------------------------------------------------------
  // Trace storage, one entry per cycle
  // -------------------------------------------------------------------------

  flowMask_t traceValid   [MaxTraceLines];
  flowData_t traceData    [MaxTraceLines][`FLOW_MUX_NUM_FLOWS];
  logic      traceReady   [MaxTraceLines];
  flowMask_t expPushReady [MaxTraceLines];
  logic      expPopValid  [MaxTraceLines];
  flowData_t expPopData   [MaxTraceLines];

  int   traceCount  = 0;
  logic traceLoaded = 1'b0;

  flowMuxRr uut (
    .clk              (clk),
    .arstN            (arstN),
    .pushValid        (pushValid),
    .pushData         (pushData),
    .pushReady        (pushReady),
    .popReady         (popReady),
    .popValidUnstable (popValidUnstable),
    .popDataUnstable  (popDataUnstable)
  );

  // Free-running clock
  initial begin : clockGen
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------

  // Compares one output against its trace value
  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input int lineIndex, input string what);
    if (actual !== expected) begin
      $display("error at time %0t: trace entry %0d, %s is %h, expected %h",
               $time, lineIndex, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  // Reads the whole trace
  // Lines starting with # are comments
  task automatic loadTrace();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] validField;
    logic [31:0] data0;
    logic [31:0] data1;
    logic [31:0] data2;
    logic [31:0] data3;
    logic [31:0] readyField;
    logic [31:0] expReadyField;
    logic [31:0] expValidField;
    logic [31:0] expDataField;
    fd = $fopen(TracePath, "r");
    if (fd == 0) begin
      $display("The trace file %s could not be opened", TracePath);
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing trace file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", validField, data0, data1,
                       data2, data3, readyField, expReadyField, expValidField,
                       expDataField);
      // Blank line
      if (fields <= 0) begin
        continue;
      end
      if (fields != 9) begin
        $display("The trace file has a line with %0d columns instead of 9: %s",
                 fields, line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "malformed trace line");
      end
      if (traceCount >= MaxTraceLines) begin
        $display("The trace file has more than %0d entries", MaxTraceLines);
        $display("TEST RESULT: FAIL");
        $fatal(1, "trace too long");
      end
      traceValid[traceCount]   = flowMask_t'(validField);
      traceData[traceCount][0] = flowData_t'(data0);
      traceData[traceCount][1] = flowData_t'(data1);
      traceData[traceCount][2] = flowData_t'(data2);
      traceData[traceCount][3] = flowData_t'(data3);
      traceReady[traceCount]   = readyField[0];
      expPushReady[traceCount] = flowMask_t'(expReadyField);
      expPopValid[traceCount]  = expValidField[0];
      expPopData[traceCount]   = flowData_t'(expDataField);
      traceCount++;
    end
    $fclose(fd);
    if (traceCount == 0) begin
      $display("The trace file %s holds no stimulus lines", TracePath);
      $display("TEST RESULT: FAIL");
      $fatal(1, "empty trace");
    end
  endtask

  // Drives one cycle of push and pop inputs
  task automatic applyLine(input int lineIndex);
    pushValid = traceValid[lineIndex];
    for (int flow = 0; flow < `FLOW_MUX_NUM_FLOWS; flow++) begin
      pushData[flow] = traceData[lineIndex][flow];
    end
    popReady = traceReady[lineIndex];
  endtask

  // All outputs are combinational, so they settle well before the edge
  task automatic checkLine(input int lineIndex);
    checkValue(32'(pushReady), 32'(expPushReady[lineIndex]), lineIndex, "pushReady");
    checkValue(32'(popValidUnstable), 32'(expPopValid[lineIndex]), lineIndex,
               "popValidUnstable");
    checkValue(32'(popDataUnstable), 32'(expPopData[lineIndex]), lineIndex,
               "popDataUnstable");
  endtask

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------

  initial begin : runTrace
    arstN     = 1'b0;
    pushValid = '0;
    popReady  = 1'b0;
    for (int flow = 0; flow < `FLOW_MUX_NUM_FLOWS; flow++) begin
      pushData[flow] = '0;
    end
    loadTrace();
    traceLoaded = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1 arstN = 1'b1;
    // Apply just after the edge and check one unit before the next one
    for (int i = 0; i < traceCount; i++) begin
      @(posedge clk);
      #1;
      applyLine(i);
      #(ClockPeriod - 2);
      checkLine(i);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Run length scales with the trace
  initial begin : watchdog
    wait (traceLoaded);
    #((traceCount + WatchdogMargin) * ClockPeriod);
    $display("Timeout: the trace did not finish within %0d clock cycles",
             traceCount + WatchdogMargin);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule : flowMuxTb

// File: testbench/flowMux_trace.txt
# Columns in hex: pushValid data0 data1 data2 data3 popReady
#   then expected pushReady popValidUnstable popDataUnstable
# Idle after reset
0 00 00 00 00 1 0 0 00
0 00 00 00 00 0 0 0 00
# All valid, flow 0 wins first, stalled then accepted
f 10 20 30 40 0 0 1 10
f 11 21 31 41 1 1 1 11
# Rotation 1, 2, 3, 0
f 12 22 32 42 1 2 1 22
f 13 23 33 43 1 4 1 33
f 14 24 34 44 1 8 1 44
f 15 25 35 45 1 1 1 15
# Single flow valid passes straight through
4 00 00 5a 00 1 4 1 5a
4 00 00 5b 00 1 4 1 5b
1 a1 00 00 00 1 1 1 a1
8 00 00 00 c3 1 8 1 c3
# Partial valids skip idle flows
a e0 61 e2 63 1 2 1 61
a e0 62 e2 64 1 8 1 64
a e0 65 e2 66 1 2 1 65
5 70 e1 72 e3 1 4 1 72
5 71 e1 73 e3 1 1 1 71
# Back-pressure holds the pending grant on flow 1
f 80 81 82 83 0 0 1 81
f 80 81 82 83 0 0 1 81
f 80 81 82 83 0 0 1 81
f 80 81 82 83 1 2 1 81
f 84 85 86 87 1 4 1 86
# Preemption under back-pressure, then all valids drop
1 90 91 92 93 0 0 1 90
9 90 91 92 93 0 0 1 93
9 90 91 92 93 0 0 1 93
0 90 91 92 93 0 0 0 00
0 90 91 92 93 1 0 0 00
9 94 95 96 97 1 8 1 97
9 98 99 9a 9b 1 1 1 98
# Earlier flows take over one after another while stalled
8 a0 a1 a2 a3 0 0 1 a3
c a0 a1 a2 a3 0 0 1 a2
e a0 a1 a2 a3 0 0 1 a1
e a0 a1 a2 a3 1 2 1 a1
e b0 b1 b2 b3 1 4 1 b2
e b4 b5 b6 b7 1 8 1 b7
e b8 b9 ba bb 1 2 1 b9
# Idle with popReady toggling, data is ignored
0 c0 c1 c2 c3 1 0 0 00
0 c0 c1 c2 c3 0 0 0 00
0 c0 c1 c2 c3 1 0 0 00
# Pointer kept across idle cycles
f d0 d1 d2 d3 1 4 1 d2
f d4 d5 d6 d7 1 8 1 d7
0 00 00 00 00 0 0 0 00

// File: list.f
+incdir+source
source/flowMuxPkg.sv
source/rrArbiter.sv
source/flowMuxCore.sv
source/flowMuxRr.sv
testbench/flowMux_props.sv
testbench/flowMuxTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the flow mux testbench with Verilator
set -e

cd "$(dirname "$0")"

logFile=sim.log
rm -rf obj_dir "$logFile"

verilator --binary --timing --assert -j 0 \
  -f list.f \
  --top-module flowMuxTb \
  -o flowMuxSim

# Run the simulation and keep its output in the log
./obj_dir/flowMuxSim > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "TEST RESULT: PASS" "$logFile"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
